// File: rv_core.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/hazard_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/rv_core.sv
testbench/rv_core_sva.sv
testbench/rv_core_tb.sv

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  hazard_if.decode             hz,
  input  rv_pipe_pkg::if_id_t  if_id_i,
  input  rv_pipe_pkg::mem_wb_t wb_i,
  output rv_pipe_pkg::id_ex_t  id_ex_o
);

  localparam int XLEN = rv_isa_pkg::XLEN;

  logic [XLEN-1:0]     insn;
  logic [2:0]          funct3;
  logic                sub_sel;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_s;
  logic [XLEN-1:0]     imm_b;
  logic [XLEN-1:0]     imm_j;
  logic [XLEN-1:0]     regs [32];
  rv_pipe_pkg::id_ex_t id_ex_d;

  // ************************************************************
  // field split and immediates
  // ************************************************************
  assign insn    = if_id_i.insn;
  assign funct3  = insn[14:12];
  assign sub_sel = (insn[6:0] == rv_isa_pkg::OPC_OP) && (insn[31:25] == rv_isa_pkg::FUNCT7_ALT);
  assign imm_i   = {{20{insn[31]}}, insn[31:20]};
  assign imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign hz.id_rs1_addr = insn[19:15];
  assign hz.id_rs2_addr = insn[24:20];

  // ************************************************************
  // register file with writeback bypass into the read
  // ************************************************************
  always_ff @(posedge clk_i)
  begin
    if (wb_i.rd_write)
      regs[wb_i.rd_addr] <= wb_i.rd_wdata;
  end

  function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0)
      return '0;
    else if (wb_i.rd_write && (wb_i.rd_addr == addr))
      return wb_i.rd_wdata;
    else
      return regs[addr];
  endfunction

  // ************************************************************
  // control decode
  // ************************************************************
  always_comb
  begin
    id_ex_d          = '0;
    id_ex_d.valid    = if_id_i.valid;
    id_ex_d.pc       = if_id_i.pc;
    id_ex_d.rs1_addr = insn[19:15];
    id_ex_d.rs2_addr = insn[24:20];
    id_ex_d.rd_addr  = insn[11:7];
    id_ex_d.rs1_data = read_reg(insn[19:15]);
    id_ex_d.rs2_data = read_reg(insn[24:20]);
    id_ex_d.imm      = imm_i;
    id_ex_d.alu_op   = rv_isa_pkg::ALU_ADD;
    if (if_id_i.valid)
    begin
      case (rv_isa_pkg::opcode_t'(insn[6:0]))
        rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM:
        begin
          id_ex_d.use_imm  = (insn[6:0] == rv_isa_pkg::OPC_OP_IMM);
          id_ex_d.rd_write = 1'b1;
          case (funct3)
            rv_isa_pkg::FUNCT3_ADD_SUB:
              id_ex_d.alu_op = sub_sel ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::FUNCT3_SLT: id_ex_d.alu_op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::FUNCT3_XOR: id_ex_d.alu_op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::FUNCT3_OR:  id_ex_d.alu_op = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::FUNCT3_AND: id_ex_d.alu_op = rv_isa_pkg::ALU_AND;
            // shifts and sltu are outside the subset
            default: id_ex_d.rd_write = 1'b0;
          endcase
        end
        rv_isa_pkg::OPC_LOAD:
        begin
          id_ex_d.use_imm  = 1'b1;
          id_ex_d.is_load  = 1'b1;
          id_ex_d.rd_write = 1'b1;
        end
        rv_isa_pkg::OPC_STORE:
        begin
          id_ex_d.use_imm  = 1'b1;
          id_ex_d.is_store = 1'b1;
          id_ex_d.imm      = imm_s;
        end
        rv_isa_pkg::OPC_BRANCH:
        begin
          id_ex_d.imm       = imm_b;
          id_ex_d.is_bne    = (funct3 == rv_isa_pkg::FUNCT3_BNE);
          id_ex_d.is_branch = (funct3 == rv_isa_pkg::FUNCT3_BEQ) ||
                              (funct3 == rv_isa_pkg::FUNCT3_BNE);
        end
        rv_isa_pkg::OPC_JAL:
        begin
          id_ex_d.imm      = imm_j;
          id_ex_d.is_jal   = 1'b1;
          id_ex_d.rd_write = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // a load-use hold leaves a bubble in ID/EX
  always_ff @(posedge clk_i)
  begin
    if (rst_i || hz.id_ex_flush || hz.if_id_stall)
    begin
      id_ex_o.valid     <= 1'b0;
      id_ex_o.is_load   <= 1'b0;
      id_ex_o.is_store  <= 1'b0;
      id_ex_o.is_branch <= 1'b0;
      id_ex_o.is_jal    <= 1'b0;
      id_ex_o.rd_write  <= 1'b0;
    end
    else
      id_ex_o <= id_ex_d;
  end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  hazard_if.execute            hz,
  input  rv_pipe_pkg::id_ex_t  id_ex_i,
  input  logic [31:0]          mem_result_i,
  input  rv_pipe_pkg::mem_wb_t wb_i,
  output rv_pipe_pkg::ex_mem_t ex_mem_o
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] src_b;
  logic [31:0] alu_result;
  logic        operands_eq;
  logic        branch_cond;
  logic        jump_taken;

  assign hz.ex_rs1_addr = id_ex_i.rs1_addr;
  assign hz.ex_rs2_addr = id_ex_i.rs2_addr;
  assign hz.ex_rd_addr  = id_ex_i.rd_addr;
  assign hz.ex_is_load  = id_ex_i.is_load;

  function automatic logic [31:0] pick(input rv_pipe_pkg::fwd_sel_t sel,
                                       input logic [31:0] reg_data);
    case (sel)
      rv_pipe_pkg::FWD_MEM: return mem_result_i;
      rv_pipe_pkg::FWD_WB:  return wb_i.rd_wdata;
      default:              return reg_data;
    endcase
  endfunction

  // forwarded operands
  // op_b also carries the store data
  always_comb
  begin
    op_a = pick(hz.fwd_a, id_ex_i.rs1_data);
    op_b = pick(hz.fwd_b, id_ex_i.rs2_data);
  end

  assign src_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;

  always_comb
  begin
    case (id_ex_i.alu_op)
      rv_isa_pkg::ALU_SUB: alu_result = op_a - src_b;
      rv_isa_pkg::ALU_AND: alu_result = op_a & src_b;
      rv_isa_pkg::ALU_OR:  alu_result = op_a | src_b;
      rv_isa_pkg::ALU_XOR: alu_result = op_a ^ src_b;
      rv_isa_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(src_b)};
      default:             alu_result = op_a + src_b;
    endcase
  end

  // branch compare always uses the register operands
  assign operands_eq = (op_a == op_b);
  assign branch_cond = id_ex_i.is_bne ? !operands_eq : operands_eq;
  assign jump_taken  = id_ex_i.valid && (id_ex_i.is_jal || (id_ex_i.is_branch && branch_cond));

  // EX/MEM register
  // redirect resolves one stage later
  always_ff @(posedge clk_i)
  begin
    if (rst_i || hz.ex_mem_flush)
    begin
      ex_mem_o.valid      <= 1'b0;
      ex_mem_o.is_load    <= 1'b0;
      ex_mem_o.is_store   <= 1'b0;
      ex_mem_o.rd_write   <= 1'b0;
      ex_mem_o.jump_taken <= 1'b0;
    end
    else
    begin
      ex_mem_o.valid       <= id_ex_i.valid;
      ex_mem_o.rd_addr     <= id_ex_i.rd_addr;
      ex_mem_o.result      <= id_ex_i.is_jal ? id_ex_i.pc + 32'd4 : alu_result;
      ex_mem_o.store_data  <= op_b;
      ex_mem_o.is_load     <= id_ex_i.is_load;
      ex_mem_o.is_store    <= id_ex_i.is_store;
      ex_mem_o.rd_write    <= id_ex_i.rd_write;
      ex_mem_o.jump_taken  <= jump_taken;
      ex_mem_o.jump_target <= id_ex_i.pc + id_ex_i.imm;
    end
  end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  hazard_if.fetch              hz,
  input  logic                 jump_taken_i,
  input  logic [31:0]          jump_target_i,
  input  logic [31:0]          imem_rdata_i,
  output logic [31:0]          imem_addr_o,
  output rv_pipe_pkg::if_id_t  if_id_o
);

  logic [31:0] pc_q;

  // redirect wins over a load-use hold
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pc_q <= RESET_PC;
    else if (jump_taken_i)
      pc_q <= jump_target_i;
    else if (!hz.if_id_stall)
      pc_q <= pc_q + 32'd4;
  end

  assign imem_addr_o = pc_q;

  // IF/ID register fed straight from the instruction memory
  always_ff @(posedge clk_i)
  begin
    if (rst_i || hz.if_id_flush)
    begin
      if_id_o.valid <= 1'b0;
      if_id_o.insn  <= rv_isa_pkg::NOP_INSN;
    end
    else if (!hz.if_id_stall)
    begin
      if_id_o.valid <= 1'b1;
      if_id_o.pc    <= pc_q;
      if_id_o.insn  <= imem_rdata_i;
    end
  end

endmodule

// File: source/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if;

  // register indices seen by the hazard logic
  logic [rv_isa_pkg::REG_ADDR_W-1:0] id_rs1_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] id_rs2_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rs1_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rs2_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rd_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] mem_rd_addr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_addr;
  logic                              ex_is_load;
  logic                              mem_rd_write;
  logic                              mem_jump_taken;
  logic                              wb_rd_write;

  // controls
  logic                              if_id_stall;
  logic                              if_id_flush;
  logic                              id_ex_flush;
  logic                              ex_mem_flush;
  rv_pipe_pkg::fwd_sel_t             fwd_a;
  rv_pipe_pkg::fwd_sel_t             fwd_b;

  modport fetch (input if_id_stall, input if_id_flush);
  modport decode (output id_rs1_addr, output id_rs2_addr,
                  input if_id_stall, input id_ex_flush);
  modport execute (output ex_rs1_addr, output ex_rs2_addr, output ex_rd_addr,
                   output ex_is_load, input fwd_a, input fwd_b, input ex_mem_flush);
  modport memory (output mem_rd_addr, output mem_rd_write, output mem_jump_taken,
                  output wb_rd_addr, output wb_rd_write);
  modport hazard (input id_rs1_addr, input id_rs2_addr, input ex_rs1_addr,
                  input ex_rs2_addr, input ex_rd_addr, input ex_is_load,
                  input mem_rd_addr, input mem_rd_write, input mem_jump_taken,
                  input wb_rd_addr, input wb_rd_write,
                  output if_id_stall, output if_id_flush, output id_ex_flush,
                  output ex_mem_flush, output fwd_a, output fwd_b);

endinterface

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  hazard_if.hazard hz
);

  logic load_use;

  // MEM result is younger, so it wins over WB
  function automatic rv_pipe_pkg::fwd_sel_t fwd_select(input logic [4:0] src);
    if (hz.mem_rd_write && (hz.mem_rd_addr != 5'd0) && (hz.mem_rd_addr == src))
      return rv_pipe_pkg::FWD_MEM;
    else if (hz.wb_rd_write && (hz.wb_rd_addr != 5'd0) && (hz.wb_rd_addr == src))
      return rv_pipe_pkg::FWD_WB;
    else
      return rv_pipe_pkg::FWD_NONE;
  endfunction

  always_comb
  begin
    hz.fwd_a = fwd_select(hz.ex_rs1_addr);
    hz.fwd_b = fwd_select(hz.ex_rs2_addr);
  end

  // load result exists only after the memory stage
  assign load_use = hz.ex_is_load && (hz.ex_rd_addr != 5'd0) &&
                    ((hz.ex_rd_addr == hz.id_rs1_addr) || (hz.ex_rd_addr == hz.id_rs2_addr));

  // ************************************************************
  // stall and flush
  // ************************************************************
  assign hz.if_id_stall  = load_use && !hz.mem_jump_taken;
  assign hz.if_id_flush  = hz.mem_jump_taken;
  assign hz.id_ex_flush  = hz.mem_jump_taken;
  assign hz.ex_mem_flush = hz.mem_jump_taken;

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  hazard_if.memory             hz,
  input  rv_pipe_pkg::ex_mem_t ex_mem_i,
  input  logic [31:0]          mem_rdata_i,
  output logic                 mem_valid_o,
  output logic                 mem_wen_o,
  output logic [31:0]          mem_addr_o,
  output logic [31:0]          mem_wdata_o,
  output logic [31:0]          mem_result_o,
  output logic                 jump_taken_o,
  output logic [31:0]          jump_target_o,
  output rv_pipe_pkg::mem_wb_t mem_wb_o
);

  // memory answers the data port in the same cycle
  assign mem_valid_o = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
  assign mem_wen_o   = ex_mem_i.valid && ex_mem_i.is_store;
  assign mem_addr_o  = ex_mem_i.result;
  assign mem_wdata_o = ex_mem_i.store_data;

  assign mem_result_o  = ex_mem_i.result;
  assign jump_taken_o  = ex_mem_i.jump_taken;
  assign jump_target_o = ex_mem_i.jump_target;

  assign hz.mem_rd_addr    = ex_mem_i.rd_addr;
  assign hz.mem_rd_write   = ex_mem_i.valid && ex_mem_i.rd_write;
  assign hz.mem_jump_taken = ex_mem_i.jump_taken;
  assign hz.wb_rd_addr     = mem_wb_o.rd_addr;
  assign hz.wb_rd_write    = mem_wb_o.rd_write;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      mem_wb_o.rd_write <= 1'b0;
    else
    begin
      mem_wb_o.rd_write <= ex_mem_i.valid && ex_mem_i.rd_write;
      mem_wb_o.rd_addr  <= ex_mem_i.rd_addr;
      mem_wb_o.rd_wdata <= ex_mem_i.is_load ? mem_rdata_i : ex_mem_i.result;
    end
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] imem_rdata_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] mem_rdata_i,
  output logic        mem_valid_o,
  output logic        mem_wen_o,
  output logic [31:0] mem_addr_o,
  output logic [31:0] mem_wdata_o
);

  hazard_if hz ();

  rv_pipe_pkg::if_id_t  if_id;
  rv_pipe_pkg::id_ex_t  id_ex;
  rv_pipe_pkg::ex_mem_t ex_mem;
  rv_pipe_pkg::mem_wb_t mem_wb;

  logic [31:0] mem_result;
  logic        jump_taken;
  logic [31:0] jump_target;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch_stage_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hz           (hz),
    .jump_taken_i (jump_taken),
    .jump_target_i(jump_target),
    .imem_rdata_i (imem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .if_id_o      (if_id)
  );

  decode_stage decode_stage_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .hz     (hz),
    .if_id_i(if_id),
    .wb_i   (mem_wb),
    .id_ex_o(id_ex)
  );

  execute_stage execute_stage_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .hz          (hz),
    .id_ex_i     (id_ex),
    .mem_result_i(mem_result),
    .wb_i        (mem_wb),
    .ex_mem_o    (ex_mem)
  );

  memory_stage memory_stage_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .hz           (hz),
    .ex_mem_i     (ex_mem),
    .mem_rdata_i  (mem_rdata_i),
    .mem_valid_o  (mem_valid_o),
    .mem_wen_o    (mem_wen_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_result_o (mem_result),
    .jump_taken_o (jump_taken),
    .jump_target_o(jump_target),
    .mem_wb_o     (mem_wb)
  );

  hazard_unit hazard_unit_inst (
    .hz(hz)
  );

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
  localparam logic [2:0] FUNCT3_BNE     = 3'b001;
  localparam logic [6:0] FUNCT7_ALT     = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

endpackage

// File: source/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic [rv_isa_pkg::XLEN-1:0]       insn;
  } if_id_t;

  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    rv_isa_pkg::alu_op_t               alu_op;
    logic                              use_imm;
    logic                              is_load;
    logic                              is_store;
    logic                              is_branch;
    logic                              is_bne;
    logic                              is_jal;
    logic                              rd_write;
  } id_ex_t;

  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_isa_pkg::XLEN-1:0]       result;
    logic [rv_isa_pkg::XLEN-1:0]       store_data;
    logic                              is_load;
    logic                              is_store;
    logic                              rd_write;
    logic                              jump_taken;
    logic [rv_isa_pkg::XLEN-1:0]       jump_target;
  } ex_mem_t;

  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_isa_pkg::XLEN-1:0]       rd_wdata;
    logic                              rd_write;
  } mem_wb_t;

endpackage

// File: testbench/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
  input logic        clk_i,
  input logic        rst_i,
  input logic [31:0] imem_addr_i,
  input logic        mem_valid_i,
  input logic        mem_wen_i
);

  // a write strobe never appears without an access
  wen_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_wen_i |-> mem_valid_i)
    else $error("mem_wen_o high while mem_valid_o is low");

  // fetch address stays on word boundaries
  pc_word_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    imem_addr_i[1:0] == 2'b00)
    else $error("imem_addr_o is not word aligned");

  // no data access right after reset
  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !mem_valid_i)
    else $error("mem_valid_o high in the cycle after reset");

endmodule

bind rv_core rv_core_sva sva_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .imem_addr_i(imem_addr_o),
  .mem_valid_i(mem_valid_o),
  .mem_wen_i  (mem_wen_o)
);

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int          NUM_TESTS    = 6;
  localparam int          PROG_LEN     = 10;
  localparam int          RESET_CYCLES = 10;
  localparam int          TEST_LIMIT   = 60;
  localparam int          RUN_LIMIT    = NUM_TESTS * (TEST_LIMIT + RESET_CYCLES) + RESET_CYCLES;
  localparam logic [31:0] SEED         = 32'ha66b_5b65;
  localparam logic [31:0] NOP          = 32'h0000_0013;
  localparam logic [31:0] MAILBOX      = 32'h0000_0100;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] imem_rdata_i;
  logic [31:0] imem_addr_o;
  logic [31:0] mem_rdata_i;
  logic        mem_valid_o;
  logic        mem_wen_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;

  // program table
  string       names    [NUM_TESTS];
  logic [31:0] progs    [NUM_TESTS][PROG_LEN];
  logic [31:0] preload  [NUM_TESTS];
  logic [31:0] expected [NUM_TESTS];

  logic [31:0] rom  [16];
  logic [31:0] dmem [256];
  int          failures;
  int          run_cycles;

  rv_core #(
    .RESET_PC(32'h0000_0000)
  ) dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .imem_rdata_i(imem_rdata_i),
    .imem_addr_o (imem_addr_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_valid_o (mem_valid_o),
    .mem_wen_o   (mem_wen_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o)
  );

  // ************************************************************
  // RV32I base format instruction encoders
  // ************************************************************
  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1, input int imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input int off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++)
      for (int k = 0; k < PROG_LEN; k++)
        progs[t][k] = NOP;
    // 12 + -5 = 7, 7 - -5 = 12, 12 ^ 7 = 11, slt -5 < 11 = 1, 11 & 12 = 8, 8 | 1 = 9
    names[0]    = "alu_chain";
    preload[0]  = 32'h0;
    expected[0] = 32'd9;
    progs[0][0] = addi(1, 0, 12);
    progs[0][1] = addi(2, 0, -5);
    progs[0][2] = reg_op(7'h00, 3'b000, 3, 1, 2);
    progs[0][3] = reg_op(7'h20, 3'b000, 4, 3, 2);
    progs[0][4] = reg_op(7'h00, 3'b100, 5, 4, 3);
    progs[0][5] = reg_op(7'h00, 3'b010, 6, 2, 5);
    progs[0][6] = reg_op(7'h00, 3'b111, 7, 5, 4);
    progs[0][7] = reg_op(7'h00, 3'b110, 8, 7, 6);
    progs[0][8] = sw(8, 0, MAILBOX);
    progs[0][9] = jal(0, 0);
    names[1]    = "load_use";
    preload[1]  = 32'h1234_5670;
    expected[1] = 32'h1234_5685;
    progs[1][0] = lw(1, 0, 32'h40);
    progs[1][1] = addi(2, 1, 32'h15);
    progs[1][2] = sw(2, 0, MAILBOX);
    progs[1][3] = jal(0, 0);
    // beq skips the +100 and +200
    names[2]    = "branch_taken";
    preload[2]  = 32'h0;
    expected[2] = 32'd10;
    progs[2][0] = addi(1, 0, 7);
    progs[2][1] = addi(2, 0, 7);
    progs[2][2] = branch(3'b000, 1, 2, 12);
    progs[2][3] = addi(1, 1, 100);
    progs[2][4] = addi(1, 1, 200);
    progs[2][5] = addi(1, 1, 3);
    progs[2][6] = sw(1, 0, MAILBOX);
    progs[2][7] = jal(0, 0);
    names[3]    = "branch_not_taken";
    preload[3]  = 32'h0;
    expected[3] = 32'd310;
    for (int k = 0; k < PROG_LEN; k++)
      progs[3][k] = progs[2][k];
    progs[3][2] = branch(3'b001, 1, 2, 12);
    // jal sits at 0x4 so the link is 0x8
    names[4]    = "jal_link";
    preload[4]  = 32'h0;
    expected[4] = 32'h0000_0008;
    progs[4][0] = addi(5, 0, 32'h55);
    progs[4][1] = jal(5, 8);
    progs[4][2] = addi(5, 5, 64);
    progs[4][3] = sw(5, 0, MAILBOX);
    progs[4][4] = jal(0, 0);
    names[5]    = "x0_write";
    preload[5]  = 32'h0;
    expected[5] = 32'h0;
    progs[5][0] = addi(1, 0, 9);
    progs[5][1] = addi(0, 1, 5);
    progs[5][2] = sw(0, 0, MAILBOX);
    progs[5][3] = jal(0, 0);
  endtask

  // ************************************************************
  // clock and memory models
  // ************************************************************
  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // both memories answer within the cycle of the request
  always @(negedge clk_i)
  begin
    imem_rdata_i <= (imem_addr_o < 32'd64) ? rom[imem_addr_o[5:2]] : NOP;
    mem_rdata_i  <= dmem[mem_addr_o[9:2]];
  end

  always @(posedge clk_i)
  begin
    if (!rst_i && mem_valid_o && mem_wen_o)
      dmem[mem_addr_o[9:2]] <= mem_wdata_o;
  end

  initial
  begin
    run_cycles = 0;
    while (run_cycles < RUN_LIMIT)
    begin
      @(posedge clk_i);
      run_cycles++;
    end
    $display("run stopped, cycle limit of %0d reached", RUN_LIMIT);
    $display("Errors found");
    $finish;
  end

  task automatic run_test(input int idx);
    int          cycles;
    logic        seen;
    logic [31:0] got;
    @(negedge clk_i);
    rst_i = 1'b1;
    for (int k = 0; k < 16; k++)
      rom[k] = (k < PROG_LEN) ? progs[idx][k] : NOP;
    // fill pattern follows the byte address
    for (int a = 0; a < 256; a++)
      dmem[a] = xorshift32(SEED ^ (a << 2));
    dmem[32'h40 >> 2] = preload[idx];
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i  = 1'b0;
    cycles = 0;
    seen   = 1'b0;
    got    = '0;
    while (!seen && cycles < TEST_LIMIT)
    begin
      @(negedge clk_i);
      cycles++;
      if (mem_valid_o && mem_wen_o && mem_addr_o == MAILBOX)
      begin
        seen = 1'b1;
        got  = mem_wdata_o;
      end
    end
    if (!seen)
    begin
      $display("test %s: no store to mailbox before timeout", names[idx]);
      failures++;
    end
    else if (got !== expected[idx])
    begin
      $display("mismatch test %s expected 0x%08h actual 0x%08h", names[idx], expected[idx], got);
      failures++;
    end
    else
      $display("pass test %s, result 0x%08h after %0d cycles", names[idx], got, cycles);
  endtask

  initial
  begin
    rst_i        = 1'b1;
    imem_rdata_i = NOP;
    mem_rdata_i  = '0;
    failures     = 0;
    build_table();
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, NUM_TESTS - failures, failures);
    if (failures == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule
